/* logic/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN    = 32;
    localparam int IMEM_AW = 10;    // 1024 words
    localparam int DMEM_AW = 10;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
    localparam logic [11:0]     HOST_CSR = 12'h51e;

    // major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
    } alu_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2, rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2, rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2, rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, seen raw or per format
    typedef union packed {
        logic [31:0] raw;
        r_fmt_t      r;
        i_fmt_t      i;
        s_fmt_t      s;
        b_fmt_t      b;
        u_fmt_t      u;
        j_fmt_t      j;
    } instr_u;

    typedef struct packed {
        alu_op_e     alu_op;
        logic        src_a_pc;      // operand a is the pc
        logic        src_b_imm;     // operand b is the immediate
        logic        is_branch;
        logic        is_jal;
        logic        is_jalr;
        logic        mem_rd;
        logic        mem_wr;
        logic        csr_wr;        // host register write
        logic        csr_imm;
        wb_sel_e     wb_sel;
        logic        rd_we;
        logic [2:0]  funct3;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic        rd_we;
        logic [4:0]  rd;
        wb_sel_e     wb_sel;
        logic [2:0]  funct3;        // load size and sign
        logic [1:0]  byte_off;
        logic [31:0] alu_res;
        logic [31:0] pc4;
    } wb_pkt_t;

endpackage

/* logic/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        redirect_i,
    input  logic [31:0] target_i,
    output logic [31:0] pc_next_o,
    output logic [31:0] pc_o,
    output logic        id_valid_o
);
    import rv_pkg::*;

    logic [31:0] resume_pc;     // restart point after reset or a taken jump

    // a bubble cycle fetches from the held target
    assign pc_next_o = id_valid_o ? pc_o + 32'd4 : resume_pc;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_o       <= RESET_PC;
            resume_pc  <= RESET_PC;
            id_valid_o <= 1'b0;
        end else begin
            pc_o       <= pc_next_o;
            id_valid_o <= !redirect_i;  // squash the wrong-path word
            if (redirect_i) begin
                resume_pc <= target_i;
            end
        end
    end

endmodule

/* logic/imem_ram.sv */
`timescale 1ns/1ns

module imem_ram (
    input  logic                       clk,
    input  logic [rv_pkg::IMEM_AW-1:0] rd_addr_i,
    input  logic                       we_i,
    input  logic [rv_pkg::IMEM_AW-1:0] wr_addr_i,
    input  logic [31:0]                wdata_i,
    output logic [31:0]                rdata_o
);
    import rv_pkg::*;

    logic [31:0] mem [2**IMEM_AW];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_addr_i] <= wdata_i;  // host load port
        end
        rdata_o <= mem[rd_addr_i];
    end

endmodule

/* logic/decode_unit.sv */
`timescale 1ns/1ns

module decode_unit (
    input  rv_pkg::instr_u instr_i,
    output rv_pkg::ctrl_t  ctrl_o
);
    import rv_pkg::*;

    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    // arithmetic op from funct3 and instruction bit 30
    function automatic alu_op_e alu_dec(input logic [2:0] f3, input logic alt,
                                        input logic sub_ok);
        alu_op_e op;
        case (f3)
            3'b000:  op = (alt && sub_ok) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign imm_i = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
    assign imm_s = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
    assign imm_b = {{20{instr_i.b.imm12}}, instr_i.b.imm11, instr_i.b.imm10_5,
                    instr_i.b.imm4_1, 1'b0};
    assign imm_u = {instr_i.u.imm, 12'h000};
    assign imm_j = {{12{instr_i.j.imm20}}, instr_i.j.imm19_12, instr_i.j.imm11,
                    instr_i.j.imm10_1, 1'b0};

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.alu_op = ALU_ADD;
        ctrl_o.wb_sel = WB_ALU;
        ctrl_o.funct3 = instr_i.r.funct3;
        ctrl_o.rs1    = instr_i.r.rs1;
        ctrl_o.rs2    = instr_i.r.rs2;
        ctrl_o.rd     = instr_i.r.rd;
        case (instr_i.r.opcode)
            OP_LUI: begin
                ctrl_o.alu_op    = ALU_PASSB;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.rd_we     = 1'b1;
                ctrl_o.imm       = imm_u;
            end
            OP_AUIPC: begin
                ctrl_o.src_a_pc  = 1'b1;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.rd_we     = 1'b1;
                ctrl_o.imm       = imm_u;
            end
            OP_JAL: begin
                ctrl_o.is_jal = 1'b1;
                ctrl_o.wb_sel = WB_PC4;   // link
                ctrl_o.rd_we  = 1'b1;
                ctrl_o.imm    = imm_j;
            end
            OP_JALR: begin
                ctrl_o.is_jalr = 1'b1;
                ctrl_o.wb_sel  = WB_PC4;
                ctrl_o.rd_we   = 1'b1;
                ctrl_o.imm     = imm_i;
            end
            OP_BRANCH: begin
                ctrl_o.is_branch = 1'b1;
                ctrl_o.imm       = imm_b;
            end
            OP_LOAD: begin
                ctrl_o.mem_rd    = 1'b1;  // address from the adder
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.rd_we     = 1'b1;
                ctrl_o.imm       = imm_i;
            end
            OP_STORE: begin
                ctrl_o.mem_wr    = 1'b1;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.imm       = imm_s;
            end
            OP_IMM: begin
                ctrl_o.alu_op    = alu_dec(instr_i.i.funct3, instr_i.r.funct7[5], 1'b0);
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.rd_we     = 1'b1;
                ctrl_o.imm       = imm_i;
            end
            OP_REG: begin
                ctrl_o.alu_op = alu_dec(instr_i.r.funct3, instr_i.r.funct7[5], 1'b1);
                ctrl_o.rd_we  = 1'b1;
            end
            OP_SYSTEM: begin
                // only csrrw and csrrwi on the host register
                if (instr_i.i.imm == HOST_CSR && instr_i.i.funct3[1:0] == 2'b01) begin
                    ctrl_o.csr_wr  = 1'b1;
                    ctrl_o.csr_imm = instr_i.i.funct3[2];
                    ctrl_o.rd_we   = 1'b1;
                    ctrl_o.imm     = {27'h0, instr_i.i.rs1};  // zimm
                end
            end
            default: ctrl_o.rd_we = 1'b0;
        endcase
    end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
    input  logic        clk,
    input  logic [4:0]  ra1_i,
    input  logic [4:0]  ra2_i,
    input  logic        we_i,
    input  logic [4:0]  wa_i,
    input  logic [31:0] wd_i,
    output logic [31:0] rd1_o,
    output logic [31:0] rd2_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we_i) begin
            regs[wa_i] <= wd_i;
        end
    end

    // x0 reads zero whatever was written
    assign rd1_o = (ra1_i == 5'd0) ? 32'h0 : regs[ra1_i];
    assign rd2_o = (ra2_i == 5'd0) ? 32'h0 : regs[ra2_i];

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       valid_i,
    input  rv_pkg::ctrl_t              ctrl_i,
    input  logic [31:0]                pc_i,
    input  logic [31:0]                rs1_data_i,
    input  logic [31:0]                rs2_data_i,
    input  logic                       fwd_we_i,
    input  logic [4:0]                 fwd_rd_i,
    input  logic [31:0]                fwd_data_i,
    output logic                       redirect_o,
    output logic [31:0]                target_o,
    output logic [rv_pkg::DMEM_AW-1:0] dmem_addr_o,
    output logic [31:0]                dmem_wdata_o,
    output logic [3:0]                 dmem_be_o,
    output logic [31:0]                host_o,
    output logic                       host_valid_o,
    output rv_pkg::wb_pkt_t            wb_o
);
    import rv_pkg::*;

    logic [31:0] rs1_val, rs2_val, op_a, op_b, alu_res, csr_val;
    logic        fwd_ok, taken, csr_fire;

    // bypass from writeback, x0 never forwarded
    assign fwd_ok  = fwd_we_i && (fwd_rd_i != 5'd0);
    assign rs1_val = (fwd_ok && fwd_rd_i == ctrl_i.rs1) ? fwd_data_i : rs1_data_i;
    assign rs2_val = (fwd_ok && fwd_rd_i == ctrl_i.rs2) ? fwd_data_i : rs2_data_i;

    assign op_a = ctrl_i.src_a_pc  ? pc_i       : rs1_val;
    assign op_b = ctrl_i.src_b_imm ? ctrl_i.imm : rs2_val;

    always_comb begin
        case (ctrl_i.alu_op)
            ALU_ADD:   alu_res = op_a + op_b;
            ALU_SUB:   alu_res = op_a - op_b;
            ALU_SLL:   alu_res = op_a << op_b[4:0];
            ALU_SLT:   alu_res = {31'h0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:  alu_res = {31'h0, op_a < op_b};
            ALU_XOR:   alu_res = op_a ^ op_b;
            ALU_SRL:   alu_res = op_a >> op_b[4:0];
            ALU_SRA:   alu_res = $signed(op_a) >>> op_b[4:0];
            ALU_OR:    alu_res = op_a | op_b;
            ALU_AND:   alu_res = op_a & op_b;
            ALU_PASSB: alu_res = op_b;
            default:   alu_res = 32'h0;
        endcase
    end

    always_comb begin
        case (ctrl_i.funct3)
            3'b000:  taken = rs1_val == rs2_val;
            3'b001:  taken = rs1_val != rs2_val;
            3'b100:  taken = $signed(rs1_val) < $signed(rs2_val);
            3'b101:  taken = $signed(rs1_val) >= $signed(rs2_val);
            3'b110:  taken = rs1_val < rs2_val;
            3'b111:  taken = rs1_val >= rs2_val;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o = valid_i && (ctrl_i.is_jal || ctrl_i.is_jalr ||
                                    (ctrl_i.is_branch && taken));
    assign target_o   = ctrl_i.is_jalr ? ((rs1_val + ctrl_i.imm) & ~32'd1)
                                       : (pc_i + ctrl_i.imm);

    // store data replicated across lanes, enables pick the bytes
    assign dmem_addr_o = alu_res[DMEM_AW+1:2];
    always_comb begin
        case (ctrl_i.funct3[1:0])
            2'b00: begin
                dmem_wdata_o = {4{rs2_val[7:0]}};
                dmem_be_o    = 4'b0001 << alu_res[1:0];
            end
            2'b01: begin
                dmem_wdata_o = {2{rs2_val[15:0]}};
                dmem_be_o    = 4'b0011 << alu_res[1:0];
            end
            default: begin
                dmem_wdata_o = rs2_val;
                dmem_be_o    = 4'b1111;
            end
        endcase
        if (!(valid_i && ctrl_i.mem_wr)) begin
            dmem_be_o = 4'b0000;
        end
    end

    assign csr_val  = ctrl_i.csr_imm ? ctrl_i.imm : rs1_val;
    assign csr_fire = valid_i && ctrl_i.csr_wr;

    always_ff @(posedge clk) begin
        wb_o.rd_we    <= ctrl_i.rd_we;
        wb_o.rd       <= ctrl_i.rd;
        wb_o.wb_sel   <= ctrl_i.mem_rd ? WB_LOAD : ctrl_i.wb_sel;
        wb_o.funct3   <= ctrl_i.funct3;
        wb_o.byte_off <= alu_res[1:0];
        wb_o.alu_res  <= ctrl_i.csr_wr ? host_o : alu_res;    // csr returns old value
        wb_o.pc4      <= pc_i + 32'd4;
        if (rst_i) begin
            wb_o.valid   <= 1'b0;
            host_o       <= 32'h0;
            host_valid_o <= 1'b0;
        end else begin
            wb_o.valid   <= valid_i;
            host_valid_o <= csr_fire;
            if (csr_fire) begin
                host_o <= csr_val;
            end
        end
    end

endmodule

/* logic/dmem_ram.sv */
`timescale 1ns/1ns

module dmem_ram (
    input  logic                       clk,
    input  logic [rv_pkg::DMEM_AW-1:0] addr_i,
    input  logic [31:0]                wdata_i,
    input  logic [3:0]                 be_i,
    output logic [31:0]                rdata_o
);
    import rv_pkg::*;

    logic [31:0] mem [2**DMEM_AW];

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (be_i[b]) begin
                mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
        rdata_o <= mem[addr_i];   // old data on a same-cycle write
    end

endmodule

/* logic/wb_stage.sv */
`timescale 1ns/1ns

module wb_stage (
    input  rv_pkg::wb_pkt_t wb_i,
    input  logic [31:0]     dmem_rdata_i,
    output logic            rf_we_o,
    output logic [4:0]      rf_wa_o,
    output logic [31:0]     rf_wd_o
);
    import rv_pkg::*;

    logic [31:0] lane;
    logic [31:0] load_val;

    // addressed byte or halfword moved down to bit 0
    assign lane = dmem_rdata_i >> {wb_i.byte_off, 3'b000};

    always_comb begin
        case (wb_i.funct3)
            3'b000:  load_val = {{24{lane[7]}}, lane[7:0]};     // lb
            3'b001:  load_val = {{16{lane[15]}}, lane[15:0]};   // lh
            3'b100:  load_val = {24'h0, lane[7:0]};
            3'b101:  load_val = {16'h0, lane[15:0]};
            default: load_val = dmem_rdata_i;
        endcase
    end

    always_comb begin
        case (wb_i.wb_sel)
            WB_LOAD: rf_wd_o = load_val;
            WB_PC4:  rf_wd_o = wb_i.pc4;
            default: rf_wd_o = wb_i.alu_res;
        endcase
    end

    assign rf_we_o = wb_i.valid && wb_i.rd_we;
    assign rf_wa_o = wb_i.rd;

endmodule

/* logic/rv_core.sv */
`timescale 1ns/1ns

module rv_core (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       imem_we_i,
    input  logic [rv_pkg::IMEM_AW-1:0] imem_addr_i,
    input  logic [31:0]                imem_wdata_i,
    output logic [31:0]                host_o,
    output logic                       host_valid_o
);
    import rv_pkg::*;

    logic [31:0]        pc_next, pc, target;
    logic               id_valid, redirect;
    instr_u             instr;
    ctrl_t              ctrl;
    logic [31:0]        rs1_data, rs2_data;
    logic               rf_we;
    logic [4:0]         rf_wa;
    logic [31:0]        rf_wd;
    logic [DMEM_AW-1:0] dmem_addr;
    logic [31:0]        dmem_wdata, dmem_rdata;
    logic [3:0]         dmem_be;
    wb_pkt_t            wb_pkt;

    fetch_stage fetch0 (
        .clk        (clk),
        .rst_i      (rst_i),
        .redirect_i (redirect),
        .target_i   (target),
        .pc_next_o  (pc_next),
        .pc_o       (pc),
        .id_valid_o (id_valid)
    );

    imem_ram imem0 (
        .clk       (clk),
        .rd_addr_i (pc_next[IMEM_AW+1:2]),
        .we_i      (imem_we_i),
        .wr_addr_i (imem_addr_i),
        .wdata_i   (imem_wdata_i),
        .rdata_o   (instr)
    );

    decode_unit dec0 (
        .instr_i (instr),
        .ctrl_o  (ctrl)
    );

    reg_file rf0 (
        .clk   (clk),
        .ra1_i (ctrl.rs1),
        .ra2_i (ctrl.rs2),
        .we_i  (rf_we),
        .wa_i  (rf_wa),
        .wd_i  (rf_wd),
        .rd1_o (rs1_data),
        .rd2_o (rs2_data)
    );

    execute_stage ex0 (
        .clk          (clk),
        .rst_i        (rst_i),
        .valid_i      (id_valid),
        .ctrl_i       (ctrl),
        .pc_i         (pc),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .fwd_we_i     (rf_we),
        .fwd_rd_i     (rf_wa),
        .fwd_data_i   (rf_wd),
        .redirect_o   (redirect),
        .target_o     (target),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_be_o    (dmem_be),
        .host_o       (host_o),
        .host_valid_o (host_valid_o),
        .wb_o         (wb_pkt)
    );

    dmem_ram dmem0 (
        .clk     (clk),
        .addr_i  (dmem_addr),
        .wdata_i (dmem_wdata),
        .be_i    (dmem_be),
        .rdata_o (dmem_rdata)
    );

    wb_stage wb0 (
        .wb_i         (wb_pkt),
        .dmem_rdata_i (dmem_rdata),
        .rf_we_o      (rf_we),
        .rf_wa_o      (rf_wa),
        .rf_wd_o      (rf_wd)
    );

endmodule

/* dv/rv_core_tb.sv */
`timescale 1ns/1ns

module rv_core_tb;
    import rv_pkg::*;

    logic               clk = 1'b0;
    logic               rst_i;
    logic               imem_we_i;
    logic [IMEM_AW-1:0] imem_addr_i;
    logic [31:0]        imem_wdata_i;
    logic [31:0]        host_o;
    logic               host_valid_o;

    logic [31:0] prog [$];          // program under construction
    logic [31:0] expect_q [$];      // host values still owed by the DUT
    logic [31:0] lfsr;
    int          checks = 0;
    int          errors = 0;
    int          missed_total = 0;
    int          cycles = 0;
    int          cycle_limit = 200;
    int          total_words = 0;

    rv_core dut0 (
        .clk          (clk),
        .rst_i        (rst_i),
        .imem_we_i    (imem_we_i),
        .imem_addr_i  (imem_addr_i),
        .imem_wdata_i (imem_wdata_i),
        .host_o       (host_o),
        .host_valid_o (host_valid_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("run stopped: cycle limit of %0d reached before the tests ended", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] ref_alu(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [31:0] r;
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_SLL:  r = a << b[4:0];
            ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:  r = a ^ b;
            ALU_SRL:  r = a >> b[4:0];
            ALU_SRA:  r = $signed(a) >>> b[4:0];
            ALU_OR:   r = a | b;
            ALU_AND:  r = a & b;
            default:  r = b;
        endcase
        return r;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        logic t;
        case (f3)
            3'b000:  t = (a == b);
            3'b001:  t = (a != b);
            3'b100:  t = ($signed(a) < $signed(b));
            3'b101:  t = ($signed(a) >= $signed(b));
            3'b110:  t = (a < b);
            default: t = (a >= b);
        endcase
        return t;
    endfunction

    function automatic logic [31:0] load_ext(input logic [31:0] word, input logic [31:0] off,
                                             input logic [2:0] f3);
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] r;
        b = 8'(word >> (off * 8));
        h = 16'(word >> (off * 8));
        case (f3)
            3'b000:  r = {{24{b[7]}}, b};
            3'b001:  r = {{16{h[15]}}, h};
            3'b100:  r = {24'h0, b};
            3'b101:  r = {16'h0, h};
            default: r = word;
        endcase
        return r;
    endfunction

    // {alt bit, funct3} of an alu operation
    function automatic logic [3:0] funct_of(input alu_op_e op);
        logic [3:0] fn;
        case (op)
            ALU_SUB:  fn = 4'b1000;
            ALU_SLL:  fn = 4'b0001;
            ALU_SLT:  fn = 4'b0010;
            ALU_SLTU: fn = 4'b0011;
            ALU_XOR:  fn = 4'b0100;
            ALU_SRL:  fn = 4'b0101;
            ALU_SRA:  fn = 4'b1101;
            ALU_OR:   fn = 4'b0110;
            ALU_AND:  fn = 4'b0111;
            default:  fn = 4'b0000;
        endcase
        return fn;
    endfunction

    function automatic logic [31:0] enc_r(input logic [3:0] fn, input int rd, input int rs1,
                                          input int rs2);
        return {1'b0, fn[3], 5'b0, 5'(rs2), 5'(rs1), fn[2:0], 5'(rd), OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                          input int rd, input int rs1, input logic [31:0] imm);
        return {imm[11:0], 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [2:0] f3, input int rs2, input int rs1,
                                          input logic [31:0] imm);
        return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                          input logic [31:0] off);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] op, input int rd,
                                          input logic [31:0] imm);
        return {imm[31:12], 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_j(input int rd, input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'(rd), OP_JAL};
    endfunction

    function automatic logic [31:0] csrw_word(input int rs);
        return enc_i(OP_SYSTEM, 3'b001, 0, rs, {20'h0, HOST_CSR});
    endfunction

    function automatic logic [31:0] csrwi_word(input int zimm);
        return enc_i(OP_SYSTEM, 3'b101, 0, zimm, {20'h0, HOST_CSR});
    endfunction

    function automatic logic [31:0] here();    // byte address of the next word
        return 32'(prog.size() * 4);
    endfunction

    task automatic emit(input logic [31:0] w);
        prog.push_back(w);
    endtask

    task automatic load_const(input int rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;   // rounds for the sign of the low part
        emit(enc_u(OP_LUI, rd, {hi[31:12], 12'h0}));
        emit(enc_i(OP_IMM, 3'b000, rd, rd, v));
    endtask

    task automatic report_reg(input int rs, input logic [31:0] exp);
        emit(csrw_word(rs));
        expect_q.push_back(exp);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t ns: %s = %08h, expected %08h", $time, name, got, exp);
        end
    endtask

    // one expected value per host strobe
    always @(negedge clk) begin
        if (!rst_i && host_valid_o) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("host register written with %08h at %0t ns when nothing was expected",
                         host_o, $time);
            end else begin
                check_value("host_o", host_o, expect_q.pop_front());
            end
        end
    end

    task automatic run_test(input string name);
        int n;
        int budget;
        int err_start;
        int missed;
        emit(enc_j(0, 32'd0));  // park in a self loop
        total_words += prog.size();
        cycle_limit = total_words * 4 + 200;
        err_start   = errors;
        @(posedge clk);
        #2;
        rst_i = 1'b1;
        for (n = 0; n < prog.size(); n++) begin
            imem_we_i    = 1'b1;
            imem_addr_i  = IMEM_AW'(n);
            imem_wdata_i = prog[n];
            @(posedge clk);
            #2;
        end
        imem_we_i = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_i  = 1'b0;
        budget = prog.size() * 2 + 20;
        n      = 0;
        while (expect_q.size() != 0 && n < budget) begin
            @(posedge clk);
            n++;
        end
        missed = expect_q.size();
        if (missed != 0) begin
            $display("%s: %0d expected host writes never arrived", name, missed);
            missed_total += missed;
            expect_q.delete();
        end
        $display("%-9s done, %0d errors", name, errors - err_start + missed);
        prog.delete();
    endtask

    task automatic test_reg_alu();
        alu_op_e     ops [10] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
                                  ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND};
        logic [31:0] a;
        logic [31:0] b;
        foreach (ops[k]) begin
            a = rand_bits(32);
            b = rand_bits(32);
            load_const(1, a);
            load_const(2, b);
            emit(enc_r(funct_of(ops[k]), 3, 1, 2));
            report_reg(3, ref_alu(ops[k], a, b));
        end
        run_test("reg_alu");
    endtask

    task automatic test_imm_alu();
        alu_op_e     ops [6] = '{ALU_ADD, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND};
        alu_op_e     shs [3] = '{ALU_SLL, ALU_SRL, ALU_SRA};
        logic [31:0] a;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [3:0]  fn;
        foreach (ops[k]) begin
            a   = rand_bits(32);
            imm = rand_bits(12);
            imm = {{20{imm[11]}}, imm[11:0]};
            fn  = funct_of(ops[k]);
            load_const(1, a);
            emit(enc_i(OP_IMM, fn[2:0], 3, 1, imm));
            report_reg(3, ref_alu(ops[k], a, imm));
        end
        foreach (shs[k]) begin
            a   = rand_bits(32);
            imm = rand_bits(5);
            fn  = funct_of(shs[k]);
            load_const(1, a);
            emit(enc_i(OP_IMM, fn[2:0], 3, 1, {21'h0, fn[3], 5'h0, imm[4:0]}));
            report_reg(3, ref_alu(shs[k], a, imm));
        end
        imm = rand_bits(20) << 12;
        emit(enc_u(OP_LUI, 4, imm));
        report_reg(4, imm);
        imm = rand_bits(20) << 12;
        pc  = here();
        emit(enc_u(OP_AUIPC, 5, imm));
        report_reg(5, pc + imm);
        run_test("imm_alu");
    endtask

    task automatic test_forward();
        logic [31:0] a;
        logic [31:0] sum;
        a   = rand_bits(32);
        sum = rand_bits(32);
        load_const(1, a);
        load_const(2, sum);
        emit(enc_s(3'b010, 2, 0, 32'h100));
        emit(enc_i(OP_LOAD, 3'b010, 5, 0, 32'h100));  // feeds the first add directly
        for (int k = 0; k < 8; k++) begin
            emit(enc_r(funct_of(ALU_ADD), 10 + k, (k == 0) ? 5 : 9 + k, 1));
        end
        for (int k = 0; k < 8; k++) begin
            sum = sum + a;
            report_reg(10 + k, sum);
        end
        run_test("forward");
    endtask

    task automatic test_bytes();
        logic [2:0]  f3s [5] = '{3'b010, 3'b000, 3'b100, 3'b001, 3'b101};
        logic [31:0] offs [5];
        logic [31:0] w;
        logic [31:0] vb;
        logic [31:0] vh;
        logic [31:0] ob;
        logic [31:0] oh;
        w  = rand_bits(32);
        vb = rand_bits(32);
        vh = rand_bits(32);
        ob = rand_bits(2);
        oh = rand_bits(1) * 2;
        offs = '{32'd0, rand_bits(2), 32'd0, rand_bits(1) * 2, 32'd0};
        offs[2] = offs[1];  // lbu reads the same byte as lb
        offs[4] = offs[3];
        load_const(1, w);
        load_const(2, vb);
        load_const(3, vh);
        emit(enc_s(3'b010, 1, 0, 32'h200));
        emit(enc_s(3'b000, 2, 0, 32'h200 + ob));
        emit(enc_s(3'b001, 3, 0, 32'h200 + oh));
        // byte then halfword merged over the stored word
        w = (w & ~(32'hFF << (ob * 8))) | ((vb & 32'hFF) << (ob * 8));
        w = (w & ~(32'hFFFF << (oh * 8))) | ((vh & 32'hFFFF) << (oh * 8));
        foreach (f3s[k]) begin
            emit(enc_i(OP_LOAD, f3s[k], 5, 0, 32'h200 + offs[k]));
            report_reg(5, load_ext(w, offs[k], f3s[k]));
        end
        run_test("bytes");
    endtask

    task automatic test_branches();
        logic [2:0]  f3s [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        logic [31:0] a;
        logic [31:0] b;
        logic        tk;
        load_const(7, 32'hBAD);
        foreach (f3s[k]) begin
            a  = rand_bits(32);
            b  = (rand_bits(1) != 0) ? a : rand_bits(32);
            tk = branch_taken(f3s[k], a, b);
            load_const(1, a);
            load_const(2, b);
            emit(enc_b(f3s[k], 1, 2, 32'd12));
            emit(tk ? csrw_word(7) : csrwi_word(2));    // squashed slot when taken
            emit(enc_j(0, 32'd8));
            emit(csrwi_word(1));
            expect_q.push_back(tk ? 32'd1 : 32'd2);
        end
        run_test("branches");
    endtask

    task automatic test_links();
        logic [31:0] pc;
        logic [31:0] z;
        load_const(7, 32'hBAD);
        pc = here();
        emit(enc_j(9, 32'd8));
        emit(csrw_word(7));
        report_reg(9, pc + 4);
        pc = here() + 8;    // jalr sits after the constant
        load_const(12, pc + 8);
        emit(enc_i(OP_JALR, 3'b000, 13, 12, 32'd1));    // odd sum, bit 0 dropped
        emit(csrw_word(7));
        emit(enc_u(OP_AUIPC, 14, 32'd0));   // shows the pc the jalr landed on
        report_reg(13, pc + 4);
        report_reg(14, pc + 8);
        z = rand_bits(5);
        emit(csrwi_word(z));
        expect_q.push_back(z);
        run_test("links");
    endtask

    initial begin
        rst_i        = 1'b1;
        imem_we_i    = 1'b0;
        imem_addr_i  = '0;
        imem_wdata_i = '0;
        lfsr         = 32'd55;
        test_reg_alu();
        test_imm_alu();
        test_forward();
        test_bytes();
        test_branches();
        test_links();
        $display("%0d checks, %0d errors, %0d missing host writes", checks, errors, missed_total);
        if (errors == 0 && missed_total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
logic/rv_pkg.sv
logic/fetch_stage.sv
logic/imem_ram.sv
logic/decode_unit.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/dmem_ram.sv
logic/wb_stage.sv
logic/rv_core.sv
dv/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module rv_core_tb -f project.f -o rv_core_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/rv_core_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
